/* Makefile */
# Verilator simulation of the prefetch buffer testbench

SRCS := $(shell cat prefetch_buffer.f)

.PHONY: run clean

run: obj_dir/Vtb_prefetch_buffer
	obj_dir/Vtb_prefetch_buffer > sim.log
	@cat sim.log
	grep -q "^Regression passed$$" sim.log

obj_dir/Vtb_prefetch_buffer: prefetch_buffer.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module tb_prefetch_buffer -f prefetch_buffer.f

clean:
	rm -rf obj_dir sim.log

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  ////////////////////
  // line geometry
  ////////////////////

  localparam int ADDR_W      = 32;
  localparam int LINE_WORDS  = 4;
  localparam int LINE_HALVES = 8;

  // byte address of an instruction or a line
  typedef logic [ADDR_W-1:0] addr_t;

  // one fetched line, word 0 sits at the lowest address
  typedef logic [LINE_WORDS-1:0][31:0] line_t;

  // a single 16-bit instruction parcel
  typedef logic [15:0] half_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    VALID,
    CROSS_FETCH
  } pf_state_t;

endpackage

`default_nettype wire

/* instr_aligner.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_aligner import fetch_pkg::*; (
  line_fetch_if.aligner la,
  input  addr_t         cur_addr_i,
  input  half_t         saved_half_i,
  input  logic          use_saved_i,
  output logic [31:0]   instr_o,
  output logic          compressed_o,
  output logic          crossword_o,
  output addr_t         next_addr_o,
  output logic          line_end_o
);

  localparam int IDX_W = $clog2(LINE_HALVES);

  half_t [LINE_HALVES-1:0] halves;
  logic  [IDX_W-1:0]       idx;
  logic  [IDX_W-1:0]       idx_next;
  half_t                   lo_half;
  half_t                   hi_half;

  // view the line as halfword parcels
  assign halves   = la.line_data;
  assign idx      = cur_addr_i[IDX_W:1];
  assign idx_next = idx + 1'b1;

  ////////////////////
  // parcel select
  ////////////////////

  // crossword: low parcel was saved from the previous line,
  // high parcel is the first one of the new line
  assign lo_half = use_saved_i ? saved_half_i : halves[idx];
  assign hi_half = use_saved_i ? halves[0] : halves[idx_next];

  assign instr_o = {hi_half, lo_half};

  assign compressed_o = (lo_half[1:0] != 2'b11);

  // a 32-bit instruction in the last parcel needs the next line
  assign crossword_o = ~use_saved_i & (idx == IDX_W'(LINE_HALVES - 1)) & ~compressed_o;

  ////////////////////
  // next address
  ////////////////////

  assign next_addr_o = cur_addr_i + (compressed_o ? addr_t'(2) : addr_t'(4));

  // next instruction no longer lies in the held line
  assign line_end_o = (next_addr_o[ADDR_W-1:IDX_W+1] != la.line_addr[ADDR_W-1:IDX_W+1]);

endmodule

`default_nettype wire

/* instr_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_mem_model (
  input  logic         clk,
  input  logic         req_i,
  input  logic [31:0]  addr_i,
  input  logic [1:0]   gnt_dly_i,
  input  logic [1:0]   rsp_dly_i,
  output logic         gnt_o,
  output logic         rvalid_o,
  output logic [127:0] rdata_o
);

  // 4 KB window of halfwords, upper address bits wrap
  logic [15:0] mem [0:2047];

  logic [31:0] line_addr;
  int          gnt_wait;
  int          rsp_wait;

  // lowest address ends up in bits 15:0
  function automatic logic [127:0] read_line(input logic [31:0] a);
    logic [127:0] line;
    logic [10:0]  base;
    line = '0;
    base = {a[11:4], 3'b000};
    for (int i = 0; i < 8; i++) begin
      line = {mem[base + 11'(i)], line[127:16]};
    end
    return line;
  endfunction

  ////////////////////
  // bus responses
  ////////////////////

  // outputs change on the falling edge only
  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    forever begin
      @(negedge clk);
      rvalid_o = 1'b0;
      if (req_i) begin
        gnt_wait = int'(gnt_dly_i);
        repeat (gnt_wait) @(negedge clk);
        // address is held stable up to the grant
        line_addr = addr_i;
        rsp_wait  = int'(rsp_dly_i);
        gnt_o     = 1'b1;
        @(negedge clk);
        gnt_o = 1'b0;
        repeat (rsp_wait) @(negedge clk);
        rdata_o  = read_line(line_addr);
        rvalid_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* line_fetch_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface line_fetch_if import fetch_pkg::*; ();

  // line request from the controller, held until fetch_ack
  logic  fetch_req;
  addr_t fetch_addr;
  logic  fetch_ack;

  // drops the held line and any response still in flight
  logic  flush;

  // current line
  logic  line_valid;
  line_t line_data;
  addr_t line_addr;

  modport ctrl (
    output fetch_req,
    output fetch_addr,
    output flush,
    input  fetch_ack,
    input  line_valid,
    input  line_data,
    input  line_addr
  );

  modport fetcher (
    input  fetch_req,
    input  fetch_addr,
    input  flush,
    output fetch_ack,
    output line_valid,
    output line_data,
    output line_addr
  );

  modport aligner (
    input  line_data,
    input  line_addr
  );

endinterface

`default_nettype wire

/* line_fetcher.sv */
`timescale 1ns/100ps
`default_nettype none

module line_fetcher import fetch_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  line_fetch_if.fetcher lf,
  output logic          instr_req_o,
  output addr_t         instr_addr_o,
  input  logic          instr_gnt_i,
  input  logic          instr_rvalid_i,
  input  line_t         instr_rdata_i,
  output logic          busy_o
);

  logic  req_q;
  addr_t addr_q;
  logic  pending_q;
  logic  stale_q;
  logic  line_valid_q;
  line_t line_q;
  addr_t line_addr_q;

  logic  start;
  logic  grant;
  logic  load_line;

  // only one transaction at a time, a new one starts once the last has returned
  assign start     = lf.fetch_req & ~req_q & ~pending_q;
  assign grant     = req_q & instr_gnt_i;
  assign load_line = pending_q & instr_rvalid_i & ~stale_q & ~lf.flush;

  ////////////////////
  // memory handshake
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q        <= 1'b0;
      pending_q    <= 1'b0;
      stale_q      <= 1'b0;
      line_valid_q <= 1'b0;
    end else begin
      if (start) begin
        req_q <= 1'b1;
      end else if (grant) begin
        req_q <= 1'b0;
      end

      if (grant) begin
        pending_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        pending_q <= 1'b0;
      end

      // a request still waiting for grant or rvalid belongs to the old stream
      if (lf.flush) begin
        stale_q <= req_q | (pending_q & ~instr_rvalid_i);
      end else if (pending_q && instr_rvalid_i) begin
        stale_q <= 1'b0;
      end

      if (lf.flush) begin
        line_valid_q <= 1'b0;
      end else if (load_line) begin
        line_valid_q <= 1'b1;
      end else if (lf.fetch_ack) begin
        line_valid_q <= 1'b0;
      end
    end
  end

  // address and line payload
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= lf.fetch_addr;
    end
    if (load_line) begin
      line_q      <= instr_rdata_i;
      line_addr_q <= addr_q;
    end
  end

  // grants of stale requests are hidden from the controller
  assign lf.fetch_ack  = grant & ~stale_q & ~lf.flush;
  assign lf.line_valid = line_valid_q;
  assign lf.line_data  = line_q;
  assign lf.line_addr  = line_addr_q;

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;
  assign busy_o       = pending_q;

endmodule

`default_nettype wire

/* prefetch_buffer.f */
fetch_pkg.sv
line_fetch_if.sv
line_fetcher.sv
instr_aligner.sv
prefetch_ctrl.sv
prefetch_buffer.sv
instr_mem_model.sv
tb_prefetch_buffer.sv

/* prefetch_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module prefetch_buffer import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // core side
  input  logic        branch_i,
  input  addr_t       addr_i,
  input  logic        ready_i,
  output logic        valid_o,
  output logic [31:0] rdata_o,
  output addr_t       addr_o,

  // instruction memory side
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  line_t       instr_rdata_i,

  output logic        busy_o
);

  logic  compressed;
  logic  crossword;
  logic  line_end;
  logic  use_saved;
  addr_t next_addr;
  half_t saved_half;

  line_fetch_if lf ();

  line_fetcher line_fetcher_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .lf             (lf.fetcher),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (busy_o)
  );

  instr_aligner instr_aligner_inst (
    .la           (lf.aligner),
    .cur_addr_i   (addr_o),
    .saved_half_i (saved_half),
    .use_saved_i  (use_saved),
    .instr_o      (rdata_o),
    .compressed_o (compressed),
    .crossword_o  (crossword),
    .next_addr_o  (next_addr),
    .line_end_o   (line_end)
  );

  prefetch_ctrl prefetch_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .lf            (lf.ctrl),
    .branch_i      (branch_i),
    .branch_addr_i (addr_i),
    .ready_i       (ready_i),
    .compressed_i  (compressed),
    .crossword_i   (crossword),
    .next_addr_i   (next_addr),
    .line_end_i    (line_end),
    .cur_addr_o    (addr_o),
    .saved_half_o  (saved_half),
    .use_saved_o   (use_saved),
    .valid_o       (valid_o)
  );

endmodule

`default_nettype wire

/* prefetch_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module prefetch_ctrl import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  line_fetch_if.ctrl lf,
  input  logic       branch_i,
  input  addr_t      branch_addr_i,
  input  logic       ready_i,
  input  logic       compressed_i,
  input  logic       crossword_i,
  input  addr_t      next_addr_i,
  input  logic       line_end_i,
  output addr_t      cur_addr_o,
  output half_t      saved_half_o,
  output logic       use_saved_o,
  output logic       valid_o
);

  localparam int LINE_BYTES = LINE_WORDS * 4;
  localparam int OFFS_W     = $clog2(LINE_BYTES);

  pf_state_t state_q;
  pf_state_t state_d;
  addr_t     cur_addr_q;
  addr_t     cur_addr_d;
  half_t     saved_half_q;
  logic      req_pend_q;

  addr_t     cur_line;
  addr_t     next_line;
  addr_t     req_line;
  logic      line_hit;
  logic      next_hit;
  logic      cross_start;
  logic      valid;
  logic      new_req;
  logic      save_half;

  assign cur_line  = {cur_addr_q[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
  assign next_line = cur_line + addr_t'(LINE_BYTES);

  // held line matches the current or the following line
  assign line_hit = lf.line_valid & (lf.line_addr == cur_line);
  assign next_hit = lf.line_valid & (lf.line_addr == next_line);

  assign cross_start = crossword_i & ~compressed_i;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d    = state_q;
    cur_addr_d = cur_addr_q;
    req_line   = cur_line;
    valid      = 1'b0;
    new_req    = 1'b0;
    save_half  = 1'b0;

    case (state_q)
      FETCH: begin
        if (line_hit) begin
          state_d = VALID;
        end
      end

      VALID: begin
        if (!line_hit) begin
          // line lost, fetch it again
          new_req = 1'b1;
          state_d = FETCH;
        end else if (cross_start) begin
          save_half = 1'b1;
          new_req   = 1'b1;
          req_line  = next_line;
          state_d   = CROSS_FETCH;
        end else begin
          valid = 1'b1;
          if (ready_i) begin
            cur_addr_d = next_addr_i;
            // last instruction of the line taken, go for the next one now
            if (line_end_i) begin
              new_req  = 1'b1;
              req_line = next_line;
              state_d  = FETCH;
            end
          end
        end
      end

      CROSS_FETCH: begin
        req_line = next_line;
        if (next_hit && !req_pend_q) begin
          valid = 1'b1;
          if (ready_i) begin
            cur_addr_d = next_addr_i;
            state_d    = VALID;
          end
        end
      end

      default: begin
        // idle until the first branch
        state_d = IDLE;
      end
    endcase

    // branches win over everything else
    if (branch_i) begin
      cur_addr_d = branch_addr_i;
      req_line   = {branch_addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
      new_req    = 1'b1;
      save_half  = 1'b0;
      state_d    = FETCH;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      cur_addr_q <= '0;
      req_pend_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      cur_addr_q <= cur_addr_d;
      req_pend_q <= lf.fetch_req & ~lf.fetch_ack;
    end
  end

  // parcel 7 of the line, low half of a crossword instruction
  always_ff @(posedge clk) begin
    if (save_half) begin
      saved_half_q <= lf.line_data[LINE_WORDS-1][31:16];
    end
  end

  assign lf.fetch_req  = req_pend_q | new_req;
  assign lf.fetch_addr = req_line;
  assign lf.flush      = branch_i;

  assign cur_addr_o   = cur_addr_q;
  assign saved_half_o = saved_half_q;
  assign use_saved_o  = (state_q == CROSS_FETCH);
  assign valid_o      = valid & ~branch_i;

endmodule

`default_nettype wire

/* tb_prefetch_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_prefetch_buffer import fetch_pkg::*; ();

  localparam int N_SEQ      = 48;
  localparam int N_CROSS    = 48;
  localparam int N_BP       = 48;
  localparam int N_ROUNDS   = 6;
  localparam int N_ROUND    = 10;
  localparam int N_TOTAL    = N_SEQ + N_CROSS + N_BP + N_ROUNDS * N_ROUND;
  localparam int MAX_CYCLES = 40 * N_TOTAL + 200;

  logic        clk;
  logic        rst_n;
  logic        branch;
  addr_t       target;
  logic        ready;
  logic        valid;
  logic [31:0] rdata;
  addr_t       addr;
  logic        instr_req;
  addr_t       instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  line_t       instr_rdata;
  logic        busy;
  logic [1:0]  gnt_dly;
  logic [1:0]  rsp_dly;

  // memory image as seen by the reference model
  half_t       img [0:2047];
  logic [31:0] rng_state;
  logic [15:0] dly_rand;

  int          errors;
  int          accepted;
  int          tests;
  int          cycles;
  int          err0;
  int          acc0;

  addr_t       ref_addr;
  logic        started;
  logic        outstanding;
  logic        hold_q;
  addr_t       hold_addr;
  logic [31:0] hold_data;
  logic        req_wait;
  addr_t       req_addr;
  half_t       h0;
  half_t       h1;

  prefetch_buffer prefetch_buffer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch),
    .addr_i         (target),
    .ready_i        (ready),
    .valid_o        (valid),
    .rdata_o        (rdata),
    .addr_o         (addr),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .busy_o         (busy)
  );

  instr_mem_model instr_mem_inst (
    .clk       (clk),
    .req_i     (instr_req),
    .addr_i    (instr_addr),
    .gnt_dly_i (gnt_dly),
    .rsp_dly_i (rsp_dly),
    .gnt_o     (instr_gnt),
    .rvalid_o  (instr_rvalid),
    .rdata_o   (instr_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [15:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  function automatic logic [10:0] half_index(input addr_t a);
    return a[11:1];
  endfunction

  task automatic write_half(input logic [10:0] idx, input half_t h);
    img[idx] = h;
    instr_mem_inst.mem[idx] = h;
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic do_branch(input addr_t t);
    branch = 1'b1;
    target = t;
    @(negedge clk);
    branch = 1'b0;
  endtask

  task automatic run_instrs(input int n, input logic random_ready);
    int          goal;
    logic [15:0] r;
    goal = accepted + n;
    while (accepted < goal) begin
      r     = rand_next();
      ready = random_ready ? r[3] : 1'b1;
      @(negedge clk);
    end
  endtask

  // granted: wait for an open response, else for a request on the bus
  task automatic wait_fetch(input logic granted);
    logic [15:0] r;
    while (granted ? !busy : !instr_req) begin
      r     = rand_next();
      ready = r[3];
      @(negedge clk);
    end
  endtask

  task automatic begin_test();
    err0 = errors;
    acc0 = accepted;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d instructions, %0d errors", tests, name,
             accepted - acc0, errors - err0);
  endtask

  ////////////////////
  // monitor
  ////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (!started) begin
        assert (!valid && !instr_req && !busy)
          else report_error("core or memory side active before the first branch");
      end
      assert (busy == outstanding)
        else report_error($sformatf("busy_o %0b, open request %0b", busy, outstanding));
      if (instr_req && instr_gnt) begin
        outstanding = 1'b1;
      end else if (instr_rvalid) begin
        outstanding = 1'b0;
      end

      // memory request holds its line address until the grant
      if (req_wait) begin
        assert (instr_req && instr_addr == req_addr)
          else report_error("memory request dropped or moved before the grant");
      end
      if (instr_req) begin
        assert (instr_addr[3:0] == 4'h0)
          else report_error($sformatf("instr_addr_o %h, expected line aligned", instr_addr));
      end
      req_wait = instr_req && !instr_gnt;
      req_addr = instr_addr;

      if (hold_q && !branch) begin
        assert (valid && addr == hold_addr && rdata == hold_data)
          else report_error("core outputs changed while ready_i was low");
      end
      hold_q    = valid && !ready && !branch;
      hold_addr = addr;
      hold_data = rdata;

      if (branch) begin
        assert (!valid) else report_error("valid_o high in a branch cycle");
        started  = 1'b1;
        ref_addr = target;
      end else if (valid && ready) begin
        // walk the image from the branch target
        h0 = img[half_index(ref_addr)];
        assert (addr == ref_addr)
          else report_error($sformatf("addr_o %h, expected %h", addr, ref_addr));
        if (h0[1:0] != 2'b11) begin
          assert (rdata[15:0] == h0)
            else report_error($sformatf("rdata_o %h, expected %h", rdata[15:0], h0));
          ref_addr = ref_addr + 32'd2;
        end else begin
          h1 = img[half_index(ref_addr + 32'd2)];
          assert (rdata == {h1, h0})
            else report_error($sformatf("rdata_o %h, expected %h", rdata, {h1, h0}));
          ref_addr = ref_addr + 32'd4;
        end
        accepted++;
      end
    end
  end

  // memory latencies for the next request
  always @(posedge clk) begin
    dly_rand = rand_next();
    gnt_dly <= dly_rand[1:0];
    rsp_dly <= dly_rand[3:2];
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [15:0] r;
    rst_n       = 1'b0;
    branch      = 1'b0;
    target      = '0;
    ready       = 1'b0;
    gnt_dly     = '0;
    rsp_dly     = '0;
    errors      = 0;
    accepted    = 0;
    tests       = 0;
    cycles      = 0;
    started     = 1'b0;
    outstanding = 1'b0;
    hold_q      = 1'b0;
    req_wait    = 1'b0;
    ref_addr    = '0;
    rng_state   = 32'hdc73;

    for (int i = 0; i < 2048; i++) begin
      write_half(11'(i), rand_next());
    end
    // lines 0x200..0x3ff: parcel 6 compressed, so parcel 7 starts a 32-bit instruction
    for (int i = 'h100; i < 'h200; i += 8) begin
      write_half(11'(i + 6), img[11'(i + 6)] & 16'hfffe);
      write_half(11'(i + 7), img[11'(i + 7)] | 16'h0003);
    end

    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    begin_test();
    repeat (20) begin
      r     = rand_next();
      ready = r[3];
      @(negedge clk);
    end
    end_test("idle after reset");

    begin_test();
    r = rand_next();
    do_branch({20'h0, 4'h8, r[7:4], 4'h0});
    run_instrs(N_SEQ, 1'b0);
    end_test("sequential stream");

    begin_test();
    r = rand_next();
    do_branch({20'h0, 4'h2, 1'b0, r[6:4], 4'h2});
    run_instrs(N_CROSS, 1'b0);
    end_test("crossword stream");

    begin_test();
    r = rand_next();
    do_branch({20'h0, 4'hc, r[7:1], 1'b0});
    run_instrs(N_BP, 1'b1);
    end_test("back-pressure");

    // branch right after an accept, on an ungranted request, on a granted one
    begin_test();
    for (int k = 0; k < N_ROUNDS; k++) begin
      if (k % 3 == 1) begin
        wait_fetch(1'b0);
      end else if (k % 3 == 2) begin
        wait_fetch(1'b1);
      end
      r = rand_next();
      do_branch({20'h0, r[11:1], 1'b0});
      run_instrs(N_ROUND, 1'b1);
    end
    end_test("branch mid-stream");

    ready = 1'b0;
    @(negedge clk);
    $display("%0d tests, %0d instructions checked, %0d errors", tests, accepted, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
